/* design/trigger_stamper.sv */
/*
  trigger-number and timestamp counters,
  trigger acceptance and record output
*/
`timescale 1ns/1ps

module trigger_stamper (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ttc_pkg::ttc_cmd_t     cmd,
  input  logic                  trigger,
  input  ttc_pkg::fill_type_e   fill_type,
  input  logic                  accept_pulse_triggers,
  output ttc_pkg::trig_record_t trig_rec,
  output logic                  trig_rec_valid
);

  import ttc_pkg::*;

  logic [TS_W-1:0]       timestamp;
  logic [TRIG_NUM_W-1:0] trig_num;
  logic [TRIG_NUM_W-1:0] trig_num_base;
  logic [TRIG_NUM_W-1:0] trig_num_next;
  logic                  trig_accept;

  // async fills only take triggers while pulse storage is on
  assign trig_accept = trigger && ((fill_type != fill_async) || accept_pulse_triggers);

  // evt_reset on the same edge makes this trigger number 1
  assign trig_num_base = cmd.evt_reset ? '0 : trig_num;
  assign trig_num_next = trig_num_base + TRIG_NUM_W'(trig_accept);

  // free-running timestamp
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timestamp <= '0;
    end else if (cmd.op == op_ts_reset) begin
      timestamp <= '0;
    end else begin
      timestamp <= timestamp + 1'b1;
    end
  end

  // trigger number, cleared by event-count reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trig_num <= '0;
    end else begin
      trig_num <= trig_num_next;
    end
  end

  // valid is a single-cycle pulse, no back-pressure
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trig_rec_valid <= 1'b0;
    end else begin
      trig_rec_valid <= trig_accept;
    end
  end

  // record payload, only meaningful with valid
  always_ff @(posedge clk) begin
    if (trig_accept) begin
      trig_rec.trig_num  <= trig_num_next;
      // value held at the sampling edge
      trig_rec.timestamp <= timestamp;
      trig_rec.fill      <= fill_type;
    end
  end

endmodule

/* design/ttc_brcst_decoder.sv */
/*
  broadcast byte classifier with registered command output
*/
`timescale 1ns/1ps

module ttc_brcst_decoder (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [7:0]        brcst,
  input  logic              brcst_str,
  output ttc_pkg::ttc_cmd_t cmd
);

  import ttc_pkg::*;

  // byte layout seen on the broadcast bus
  // xxxxxx1x  event-count reset, may ride along with any command
  // 1ff x0xxx fill type, ff != 00 is a sync fill, ff == 00 is async
  // 10sx1xxx  pulse storage, s = 0 starts and s = 1 stops
  // 001x1xxx  timestamp reset

  ttc_cmd_t cmd_next;

  always_comb begin
    cmd_next = CMD_IDLE;
    if (brcst_str) begin
      // evt_reset bit is independent of the opcode
      cmd_next.evt_reset = brcst[1];
      if (!brcst[3] && brcst[7] && (brcst[6:5] != 2'b00)) begin
        cmd_next.op   = op_fill_sync;
        cmd_next.fill = fill_type_e'({1'b0, brcst[6:5]});
      end else if ((brcst[7:5] == 3'b100) && !brcst[3]) begin
        cmd_next.op = op_fill_async;
      end else if ((brcst[7:6] == 2'b10) && brcst[3]) begin
        // bit 5 picks start or stop
        if (brcst[5]) begin
          cmd_next.op = op_pulse_stop;
        end else begin
          cmd_next.op = op_pulse_start;
        end
      end else if ((brcst[7:5] == 3'b001) && brcst[3]) begin
        cmd_next.op = op_ts_reset;
      end else if (brcst[1]) begin
        // pure event-count reset, nothing else encoded
        cmd_next.op = op_none;
      end else begin
        cmd_next.op = op_unknown;
      end
    end
  end

  // one cycle of latency from strobe to command
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd <= CMD_IDLE;
    end else begin
      cmd <= cmd_next;
    end
  end

endmodule

/* design/ttc_chanb_receiver.sv */
/*
  channel B state: fill type, pulse-storage enable,
  unknown-command counter and its error flag
*/
`timescale 1ns/1ps

module ttc_chanb_receiver #(
  parameter int CNT_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ttc_loopback,
  input  ttc_pkg::ttc_cmd_t     cmd,
  input  logic [CNT_WIDTH-1:0]  thres_unknown,
  output ttc_pkg::fill_type_e   fill_type,
  output logic                  accept_pulse_triggers,
  output logic [CNT_WIDTH-1:0]  unknown_count,
  output logic                  error_unknown
);

  import ttc_pkg::*;

  fill_type_e           fill_next;
  logic                 accept_next;
  logic [CNT_WIDTH-1:0] count_next;

  // hard error once soft errors pass the threshold
  assign error_unknown = (unknown_count > thres_unknown);

  always_comb begin
    // hold by default
    fill_next   = fill_type;
    accept_next = accept_pulse_triggers;
    count_next  = unknown_count;
    case (cmd.op)
      op_fill_sync: begin
        fill_next = cmd.fill;
      end
      op_fill_async: begin
        fill_next = fill_async;
      end
      op_pulse_start: begin
        accept_next = 1'b1;
      end
      op_pulse_stop: begin
        accept_next = 1'b0;
      end
      op_unknown: begin
        // counter wraps on overflow
        count_next = unknown_count + 1'b1;
      end
      default: begin
        // op_none and op_ts_reset leave the state alone
        fill_next = fill_type;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_type             <= fill_muon;
      accept_pulse_triggers <= 1'b0;
      unknown_count         <= '0;
    end else if (ttc_loopback) begin
      // optical loopback forces the reset values every cycle
      fill_type             <= fill_muon;
      accept_pulse_triggers <= 1'b0;
      unknown_count         <= '0;
    end else begin
      fill_type             <= fill_next;
      accept_pulse_triggers <= accept_next;
      unknown_count         <= count_next;
    end
  end

endmodule

/* design/ttc_pkg.sv */
/*
  TTC opcode and fill-type enums, decoded command struct,
  trigger record struct and its field widths
*/
package ttc_pkg;

  // record field widths
  localparam int TRIG_NUM_W = 24;
  localparam int TS_W       = 40;

  // opcode of one decoded broadcast byte
  typedef enum logic [2:0] {
    op_none        = 3'd0,
    op_fill_sync   = 3'd1,
    op_fill_async  = 3'd2,
    op_pulse_start = 3'd3,
    op_pulse_stop  = 3'd4,
    op_ts_reset    = 3'd5,
    op_unknown     = 3'd6
  } ttc_op_e;

  // run fill type, encoding as carried by channel B
  typedef enum logic [2:0] {
    fill_muon     = 3'd1,
    fill_laser    = 3'd2,
    fill_pedestal = 3'd3,
    fill_async    = 3'd7
  } fill_type_e;

  // registered decoder output
  // fill is only meaningful with op_fill_sync
  typedef struct packed {
    ttc_op_e    op;
    logic       evt_reset;
    fill_type_e fill;
  } ttc_cmd_t;

  // idle command between strobes
  localparam ttc_cmd_t CMD_IDLE = '{op: op_none, evt_reset: 1'b0, fill: fill_muon};

  // one stamped trigger
  typedef struct packed {
    logic [TRIG_NUM_W-1:0] trig_num;
    logic [TS_W-1:0]       timestamp;
    fill_type_e            fill;
  } trig_record_t;

endpackage

/* design/ttc_trigger_top.sv */
/*
  trigger front end top level: decoder, channel B receiver, stamper
*/
`timescale 1ns/1ps

module ttc_trigger_top #(
  parameter int CNT_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [7:0]            brcst,
  input  logic                  brcst_str,
  input  logic                  ttc_loopback,
  input  logic                  trigger,
  input  logic [CNT_WIDTH-1:0]  thres_unknown,
  output ttc_pkg::fill_type_e   fill_type,
  output logic                  accept_pulse_triggers,
  output logic [CNT_WIDTH-1:0]  unknown_count,
  output logic                  error_unknown,
  output ttc_pkg::trig_record_t trig_rec,
  output logic                  trig_rec_valid
);

  import ttc_pkg::*;

  // decoded broadcast, shared by receiver and stamper
  ttc_cmd_t cmd;

  ttc_brcst_decoder decoder_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .brcst     (brcst),
    .brcst_str (brcst_str),
    .cmd       (cmd)
  );

  ttc_chanb_receiver #(
    .CNT_WIDTH (CNT_WIDTH)
  ) receiver_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .ttc_loopback          (ttc_loopback),
    .cmd                   (cmd),
    .thres_unknown         (thres_unknown),
    .fill_type             (fill_type),
    .accept_pulse_triggers (accept_pulse_triggers),
    .unknown_count         (unknown_count),
    .error_unknown         (error_unknown)
  );

  // stamper reads receiver state directly
  trigger_stamper stamper_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .cmd                   (cmd),
    .trigger               (trigger),
    .fill_type             (fill_type),
    .accept_pulse_triggers (accept_pulse_triggers),
    .trig_rec              (trig_rec),
    .trig_rec_valid        (trig_rec_valid)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ttc_trigger_top \
  -f ttc_trigger_top.f -o sim_tb \
  && ./obj_dir/sim_tb +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -x "all tests passed" > /dev/null \
  && echo "simulation PASSED" && exit 0 \
  || { echo "simulation FAILED"; exit 1; }

/* testbench/tb_ttc_trigger_top.sv */
/*
  trigger front end testbench with stimulus table, LFSR random phase,
  cycle reference model, record monitor and watchdog
*/
`timescale 1ns/1ps

module tb_ttc_trigger_top;

  import ttc_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_ROWS   = 24;
  localparam int NUM_RAND   = 150;
  localparam int TIMEOUT_NS = (NUM_ROWS + NUM_RAND) * 4 * CLK_PERIOD + 400;

  // stimulus plus the state expected once the row has settled
  typedef struct packed {
    logic [7:0]  brcst;
    logic        str;
    logic        trg;
    logic        lb;
    fill_type_e  exp_fill;
    logic        exp_accept;
    logic [31:0] exp_count;
  } row_t;

  logic         clk;
  logic         rst_n;
  logic [7:0]   brcst;
  logic         brcst_str;
  logic         ttc_loopback;
  logic         trigger;
  logic [31:0]  thres_unknown;
  fill_type_e   fill_type;
  logic         accept_pulse_triggers;
  logic [31:0]  unknown_count;
  logic         error_unknown;
  trig_record_t trig_rec;
  logic         trig_rec_valid;

  int          errors    = 0;
  int          checks    = 0;
  int          rec_count = 0;
  logic [31:0] lfsr_state = 32'h70768273;

  // reference model state as it stands after the latest clock edge
  ttc_cmd_t              m_cmd;
  fill_type_e            m_fill;
  logic                  m_accept;
  logic [31:0]           m_count;
  logic [TS_W-1:0]       m_ts;
  logic [TRIG_NUM_W-1:0] m_num;
  logic                  m_take;
  logic                  m_rec_valid;
  trig_record_t          m_rec;

  row_t rows [NUM_ROWS] = '{
    // byte  str   trg   lb    fill           acc   count
    '{8'h00, 1'b0, 1'b0, 1'b0, fill_muon,     1'b0, 32'd0},
    '{8'hc0, 1'b1, 1'b1, 1'b0, fill_laser,    1'b0, 32'd0},
    '{8'he0, 1'b1, 1'b0, 1'b0, fill_pedestal, 1'b0, 32'd0},
    '{8'ha0, 1'b1, 1'b1, 1'b0, fill_muon,     1'b0, 32'd0},
    '{8'h80, 1'b1, 1'b0, 1'b0, fill_async,    1'b0, 32'd0},
    '{8'h00, 1'b0, 1'b1, 1'b0, fill_async,    1'b0, 32'd0},
    '{8'h88, 1'b1, 1'b0, 1'b0, fill_async,    1'b1, 32'd0},
    '{8'h00, 1'b0, 1'b1, 1'b0, fill_async,    1'b1, 32'd0},
    '{8'h00, 1'b0, 1'b1, 1'b0, fill_async,    1'b1, 32'd0},
    '{8'ha8, 1'b1, 1'b0, 1'b0, fill_async,    1'b0, 32'd0},
    '{8'h00, 1'b0, 1'b1, 1'b0, fill_async,    1'b0, 32'd0},
    '{8'hc0, 1'b1, 1'b0, 1'b0, fill_laser,    1'b0, 32'd0},
    '{8'h00, 1'b0, 1'b1, 1'b0, fill_laser,    1'b0, 32'd0},
    '{8'h00, 1'b1, 1'b0, 1'b0, fill_laser,    1'b0, 32'd1},
    '{8'h02, 1'b1, 1'b1, 1'b0, fill_laser,    1'b0, 32'd1},
    '{8'h00, 1'b0, 1'b1, 1'b0, fill_laser,    1'b0, 32'd1},
    '{8'h28, 1'b1, 1'b1, 1'b0, fill_laser,    1'b0, 32'd1},
    '{8'h00, 1'b0, 1'b1, 1'b0, fill_laser,    1'b0, 32'd1},
    '{8'h00, 1'b1, 1'b0, 1'b0, fill_laser,    1'b0, 32'd2},
    '{8'h00, 1'b1, 1'b0, 1'b0, fill_laser,    1'b0, 32'd3},
    '{8'h88, 1'b1, 1'b0, 1'b0, fill_laser,    1'b1, 32'd3},
    '{8'he0, 1'b1, 1'b0, 1'b0, fill_pedestal, 1'b1, 32'd3},
    '{8'h00, 1'b0, 1'b0, 1'b1, fill_muon,     1'b0, 32'd0},
    '{8'h00, 1'b0, 1'b1, 1'b0, fill_muon,     1'b0, 32'd0}
  };

  ttc_trigger_top dut_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .brcst                 (brcst),
    .brcst_str             (brcst_str),
    .ttc_loopback          (ttc_loopback),
    .trigger               (trigger),
    .thres_unknown         (thres_unknown),
    .fill_type             (fill_type),
    .accept_pulse_triggers (accept_pulse_triggers),
    .unknown_count         (unknown_count),
    .error_unknown         (error_unknown),
    .trig_rec              (trig_rec),
    .trig_rec_valid        (trig_rec_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // galois LFSR stepped once per bit taken
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[k] = lfsr_bit();
    end
    return v;
  endfunction

  // broadcast byte rules grouped on b[7:5] and b[3]
  function automatic ttc_cmd_t classify_byte(input logic [7:0] b, input logic str);
    ttc_cmd_t c;
    c = CMD_IDLE;
    if (str) begin
      c.evt_reset = b[1];
      casez ({b[7:5], b[3]})
        4'b1??0: c.op = (b[6:5] != 2'b00) ? op_fill_sync : op_fill_async;
        4'b10?1: c.op = b[5] ? op_pulse_stop : op_pulse_start;
        4'b0011: c.op = op_ts_reset;
        default: c.op = b[1] ? op_none : op_unknown;
      endcase
      if (c.op == op_fill_sync) begin
        c.fill = fill_type_e'({1'b0, b[6:5]});
      end
    end
    return c;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
    end
  endtask

  // strobe on the first edge and trigger on the second
  // state has settled by the negedge after the third
  task automatic apply_row(input logic [7:0] b, input logic str, input logic trg,
                           input logic lb);
    @(posedge clk);
    brcst        <= b;
    brcst_str    <= str;
    ttc_loopback <= lb;
    @(posedge clk);
    brcst_str <= 1'b0;
    trigger   <= trg;
    @(posedge clk);
    trigger <= 1'b0;
    @(negedge clk);
  endtask

  // reference model and record monitor checked and stepped at each negedge
  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      m_cmd       = CMD_IDLE;
      m_fill      = fill_muon;
      m_accept    = 1'b0;
      m_count     = '0;
      m_ts        = '0;
      m_num       = '0;
      m_rec_valid = 1'b0;
    end else begin
      compare_value("fill_type", 64'(fill_type), 64'(m_fill));
      compare_value("accept_pulse_triggers", 64'(accept_pulse_triggers), 64'(m_accept));
      compare_value("unknown_count", 64'(unknown_count), 64'(m_count));
      compare_value("error_unknown", 64'(error_unknown), 64'(m_count > thres_unknown));
      compare_value("trig_rec_valid", 64'(trig_rec_valid), 64'(m_rec_valid));
      if (m_rec_valid) begin
        rec_count++;
        compare_value("trig_rec.trig_num", 64'(trig_rec.trig_num), 64'(m_rec.trig_num));
        compare_value("trig_rec.timestamp", 64'(trig_rec.timestamp), 64'(m_rec.timestamp));
        compare_value("trig_rec.fill", 64'(trig_rec.fill), 64'(m_rec.fill));
      end
      // at the next edge the stamper sees the old state and the current trigger
      m_take      = trigger && ((m_fill != fill_async) || m_accept);
      m_num       = (m_cmd.evt_reset ? '0 : m_num) + TRIG_NUM_W'(m_take);
      m_rec_valid = m_take;
      if (m_take) begin
        m_rec = '{trig_num: m_num, timestamp: m_ts, fill: m_fill};
      end
      m_ts = (m_cmd.op == op_ts_reset) ? '0 : m_ts + TS_W'(1);
      if (ttc_loopback) begin
        m_fill   = fill_muon;
        m_accept = 1'b0;
        m_count  = '0;
      end else begin
        case (m_cmd.op)
          op_fill_sync:   m_fill = m_cmd.fill;
          op_fill_async:  m_fill = fill_async;
          op_pulse_start: m_accept = 1'b1;
          op_pulse_stop:  m_accept = 1'b0;
          op_unknown:     m_count = m_count + 32'd1;
          default:        ;
        endcase
      end
      m_cmd = classify_byte(brcst, brcst_str);
    end
  end

  // watchdog sized from the number of rows and random draws
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not complete within %0d ns", TIMEOUT_NS);
    $display("tests failed");
    $finish;
  end

  initial begin : stimulus
    logic [7:0] rnd_byte;
    logic       rnd_str;
    logic       rnd_trg;
    logic [7:0] lb_draw;
    brcst         = '0;
    brcst_str     = 1'b0;
    ttc_loopback  = 1'b0;
    trigger       = 1'b0;
    thres_unknown = 32'd2;
    rst_n         = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i].brcst, rows[i].str, rows[i].trg, rows[i].lb);
      compare_value("fill_type", 64'(fill_type), 64'(rows[i].exp_fill));
      compare_value("accept_pulse_triggers", 64'(accept_pulse_triggers),
                    64'(rows[i].exp_accept));
      compare_value("unknown_count", 64'(unknown_count), 64'(rows[i].exp_count));
    end
    // random bytes checked by the model alone
    for (int i = 0; i < NUM_RAND; i++) begin
      rnd_byte = rand_bits(8);
      rnd_str  = lfsr_bit();
      rnd_trg  = lfsr_bit();
      lb_draw  = rand_bits(3);
      apply_row(rnd_byte, rnd_str, rnd_trg, lb_draw == 8'd0);
    end
    repeat (3) @(negedge clk);
    assert (rec_count > 0) else begin
      errors++;
      $display("no trigger record was produced during the run");
    end
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut_i.checker_i.fail_count);
    if (errors == 0 && dut_i.checker_i.fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* testbench/ttc_trigger_checker.sv */
/*
  concurrent assertions on the trigger front end top level, bound by module
*/
`timescale 1ns/1ps

module ttc_trigger_checker #(
  parameter int CNT_WIDTH = 32
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 trigger,
  input logic [CNT_WIDTH-1:0] thres_unknown,
  input ttc_pkg::fill_type_e  fill_type,
  input logic [CNT_WIDTH-1:0] unknown_count,
  input logic                 error_unknown,
  input logic                 trig_rec_valid
);

  import ttc_pkg::*;

  // read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // error flag tracks count against threshold
  a_error_flag: assert property (@(posedge clk) disable iff (!rst_n)
    error_unknown == (unknown_count > thres_unknown))
    else begin
      fail_count++;
      $error("error_unknown disagrees with unknown_count and thres_unknown");
    end

  // only the four channel B encodings
  a_fill_legal: assert property (@(posedge clk) disable iff (!rst_n)
    fill_type inside {fill_muon, fill_laser, fill_pedestal, fill_async})
    else begin
      fail_count++;
      $error("fill_type holds an illegal encoding");
    end

  // a record needs a trigger on the cycle before
  a_valid_cause: assert property (@(posedge clk) disable iff (!rst_n)
    trig_rec_valid |-> $past(trigger))
    else begin
      fail_count++;
      $error("trig_rec_valid raised without a trigger one cycle earlier");
    end

endmodule

bind ttc_trigger_top ttc_trigger_checker #(
  .CNT_WIDTH (CNT_WIDTH)
) checker_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .trigger        (trigger),
  .thres_unknown  (thres_unknown),
  .fill_type      (fill_type),
  .unknown_count  (unknown_count),
  .error_unknown  (error_unknown),
  .trig_rec_valid (trig_rec_valid)
);

/* ttc_trigger_top.f */
design/ttc_pkg.sv
design/ttc_brcst_decoder.sv
design/ttc_chanb_receiver.sv
design/trigger_stamper.sv
design/ttc_trigger_top.sv
testbench/ttc_trigger_checker.sv
testbench/tb_ttc_trigger_top.sv
